//--- mipsCluster.f
+incdir+design
design/mipsPkg.sv
design/memBus.sv
design/instrDecoder.sv
design/alu.sv
design/execLane.sv
design/sharedDataRam.sv
design/mipsCluster.sv
test/tbClock.sv
test/tbMipsCluster.sv

//--- Bender.yml
package:
  name: mipsCluster

export_include_dirs:
  - design

sources:
  - files:
      - design/mipsPkg.sv
      - design/memBus.sv
      - design/instrDecoder.sv
      - design/alu.sv
      - design/execLane.sv
      - design/sharedDataRam.sv
      - design/mipsCluster.sv
  - target: test
    files:
      - test/tbClock.sv
      - test/tbMipsCluster.sv

//--- test/tbMipsCluster.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
`default_nettype none

module tbMipsCluster;

    localparam int TimeoutCycles = 1000;

    wire         clk;
    logic        rst;
    logic        instValid [2];
    wire         instReady [2];
    logic [31:0] instInstr [2];
    logic [31:0] instRs    [2];
    logic [31:0] instRt    [2];
    wire         resValid  [2];
    logic        resReady  [2];
    wire  [31:0] resData   [2];

    integer      seed;
    int          errorCount;
    int          timeoutCount;
    int          pending [2];
    logic        stallOn;
    logic [31:0] model [0:`RAM_DEPTH-1];   // Expected RAM contents, written at store issue

    logic [5:0] calcFuncts [10] = '{`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND,
                                    `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU};
    logic [5:0] shiftFuncts [6] = '{`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV};
    logic [5:0] immOps [8]      = '{`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
                                    `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};
    logic [31:0] edgeWords [5]  = '{32'h0, 32'hffff_ffff, 32'h8000_0000,
                                    32'h7fff_ffff, 32'hfff0_0000};

    tbClock clockGen (
        .clk (clk)
    );

    mipsCluster i_mipsCluster (
        .clk        (clk),
        .rst        (rst),
        .inst0Valid (instValid[0]),
        .inst0Ready (instReady[0]),
        .inst0Instr (instInstr[0]),
        .inst0Rs    (instRs[0]),
        .inst0Rt    (instRt[0]),
        .res0Valid  (resValid[0]),
        .res0Ready  (resReady[0]),
        .res0Data   (resData[0]),
        .inst1Valid (instValid[1]),
        .inst1Ready (instReady[1]),
        .inst1Instr (instInstr[1]),
        .inst1Rs    (instRs[1]),
        .inst1Rt    (instRt[1]),
        .res1Valid  (resValid[1]),
        .res1Ready  (resReady[1]),
        .res1Data   (resData[1])
    );

    function automatic logic [31:0] rType(input logic [5:0] op, input logic [5:0] fn,
                                          input logic [4:0] sa);
        return {op, 5'd1, 5'd2, 5'd3, sa, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [15:0] imm);
        return {op, 5'd1, 5'd2, imm};
    endfunction

    function automatic logic [31:0] countLeading(input logic [31:0] word, input logic bitVal);
        int   count;
        logic run;
        count = 0;
        run   = 1'b1;
        for (int i = 31; i >= 0; i--)
        begin
            if (run && word[i] == bitVal)
                count++;
            else
                run = 1'b0;
        end
        return count;
    endfunction

    function automatic logic [31:0] refResult(input logic [31:0] instr, rs, rt);
        logic [4:0]  sa;
        logic [31:0] simm;
        logic [31:0] zimm;
        sa   = instr[10:6];
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0, instr[15:0]};
        case (instr[31:26])
            `OP_SPECIAL:
                case (instr[5:0])
                    `FN_SLL:           return rt << sa;
                    `FN_SRL:           return rt >> sa;
                    `FN_SRA:           return $signed(rt) >>> sa;
                    `FN_SLLV:          return rt << rs[4:0];
                    `FN_SRLV:          return rt >> rs[4:0];
                    `FN_SRAV:          return $signed(rt) >>> rs[4:0];
                    `FN_ADD, `FN_ADDU: return rs + rt;
                    `FN_SUB, `FN_SUBU: return rs - rt;
                    `FN_AND:           return rs & rt;
                    `FN_OR:            return rs | rt;
                    `FN_XOR:           return rs ^ rt;
                    `FN_NOR:           return ~(rs | rt);
                    `FN_SLT:           return {31'd0, $signed(rs) < $signed(rt)};
                    `FN_SLTU:          return {31'd0, rs < rt};
                    default:           return 32'h0;
                endcase
            `OP_SPECIAL2:
                case (instr[5:0])
                    `FN2_CLO: return countLeading(rs, 1'b1);
                    `FN2_CLZ: return countLeading(rs, 1'b0);
                    default:  return 32'h0;
                endcase
            `OP_ADDI, `OP_ADDIU, `OP_LW, `OP_SW: return rs + simm;
            `OP_SLTI:  return {31'd0, $signed(rs) < $signed(simm)};
            `OP_SLTIU: return {31'd0, rs < simm};
            `OP_ANDI:  return rs & zimm;
            `OP_ORI:   return rs | zimm;
            `OP_XORI:  return rs ^ zimm;
            `OP_LUI:   return {instr[15:0], 16'h0};
            default:   return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] expectedFor(input logic [31:0] instr, rs, rt);
        logic [31:0] addr;
        addr = refResult(instr, rs, rt);
        if (instr[31:26] == `OP_SW)
            model[addr[9:2]] = rt;
        if (instr[31:26] == `OP_LW)
            return model[addr[9:2]];
        return addr;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("error %s: got %h, expected %h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic sendInstr(input int lane, input logic [31:0] instr, rs, rt);
        int cycles;
        cycles          = 0;
        instValid[lane] = 1'b1;
        instInstr[lane] = instr;
        instRs[lane]    = rs;
        instRt[lane]    = rt;
        while (!instReady[lane] && cycles < TimeoutCycles)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!instReady[lane])
        begin
            $display("Lane %0d never became ready to take an instruction", lane);
            timeoutCount++;
        end
        else
        begin
            @(posedge clk);             // Ready was high all cycle so the transfer is here
            #1;
        end
        instValid[lane] = 1'b0;
    endtask

    task automatic sendPair(input logic [31:0] instr0, rs0, rt0, instr1, rs1, rt1);
        fork
            sendInstr(0, instr0, rs0, rt0);
            sendInstr(1, instr1, rs1, rt1);
        join
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while ((pending[0] != 0 || pending[1] != 0) && cycles < TimeoutCycles)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (pending[0] != 0 || pending[1] != 0)
        begin
            $display("Results never came back, %0d and %0d still pending",
                     pending[0], pending[1]);
            timeoutCount++;
        end
    endtask

    for (genvar n = 0; n < 2; n++)
    begin : laneCheck
        logic [31:0] expQ [$];
        logic [31:0] heldData;
        logic        wasStalled;
        int          span;

        // Compares results in issue order and watches held outputs under back-pressure
        always @(posedge clk)
        begin
            if (rst)
                wasStalled = 1'b0;
            else
            begin
                if (wasStalled)
                begin
                    if (!resValid[n])
                    begin
                        $display("Lane %0d dropped its result while it was stalled", n);
                        errorCount++;
                    end
                    checkValue($sformatf("res%0dData", n), resData[n], heldData);
                end
                if (instValid[n] && instReady[n])
                begin
                    expQ.push_back(expectedFor(instInstr[n], instRs[n], instRt[n]));
                    pending[n]++;
                end
                if (resValid[n] && resReady[n])
                begin
                    if (expQ.size() == 0)
                    begin
                        $display("Lane %0d returned a result with nothing outstanding", n);
                        errorCount++;
                    end
                    else
                    begin
                        checkValue($sformatf("res%0dData", n), resData[n], expQ.pop_front());
                        pending[n]--;
                    end
                end
                wasStalled = resValid[n] && !resReady[n];
                heldData   = resData[n];
            end
        end

        initial
        begin
            resReady[n] = 1'b1;
            span        = 0;
            forever
            begin
                @(posedge clk);
                #1;
                if (!stallOn)
                    resReady[n] = 1'b1;
                else if (span > 0)
                    span--;
                else
                begin
                    resReady[n] = ~resReady[n];
                    span        = $unsigned($random(seed)) % 6;
                end
            end
        end
    end

    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [15:0] imm;
        seed         = 32'hf607;
        errorCount   = 0;
        timeoutCount = 0;
        pending      = '{0, 0};
        stallOn      = 1'b0;
        rst          = 1'b1;
        for (int n = 0; n < 2; n++)
        begin
            instValid[n] = 1'b0;
            instInstr[n] = 32'h0;
            instRs[n]    = 32'h0;
            instRt[n]    = 32'h0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 40; i++)
        begin
            a = $random(seed);
            b = (i % 8 == 0) ? a : $random(seed);
            c = $random(seed);
            d = $random(seed);
            sendPair(rType(`OP_SPECIAL, calcFuncts[i % 10], 5'd0), a, b,
                     rType(`OP_SPECIAL, calcFuncts[(i + 3) % 10], 5'd0), c, d);
        end

        for (int i = 0; i < 24; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            c = $random(seed);
            if ((i / 6) % 2)
            begin
                a[31] = 1'b1;           // Negative values for the arithmetic shifts
                b[31] = 1'b1;
            end
            sendPair(rType(`OP_SPECIAL, shiftFuncts[i % 6], c[4:0]), a, b,
                     rType(`OP_SPECIAL, shiftFuncts[(i + 2) % 6], c[9:5]), b, a);
        end

        for (int i = 0; i < 32; i++)
        begin
            a   = $random(seed);
            b   = $random(seed);
            imm = $random(seed);
            imm[15] = i[3];
            sendPair(iType(immOps[i % 8], imm), a, b, iType(immOps[(i + 4) % 8], imm), b, a);
        end

        for (int i = 0; i < 12; i++)
        begin
            a = (i < 5) ? edgeWords[i] : $random(seed);
            sendPair(rType(`OP_SPECIAL2, `FN2_CLO, 5'd0), a, 32'h0,
                     rType(`OP_SPECIAL2, `FN2_CLZ, 5'd0), a, 32'h0);
        end
        sendPair(rType(6'h3f, 6'h2a, 5'd3), 32'h1234, 32'h5678,
                 rType(`OP_SPECIAL, 6'h01, 5'd0), 32'h1, 32'h2);
        sendPair(rType(`OP_SPECIAL2, 6'h00, 5'd0), 32'h9, 32'h9,
                 iType(6'h04, 16'h0010), 32'h7, 32'h7);

        // Lane 0 stores to words 0 to 15, lane 1 to words 64 to 79
        for (int i = 0; i < 16; i++)
        begin
            a = $random(seed) & 32'hffff_fc00;
            b = $random(seed);
            c = $random(seed) & 32'hffff_fc00;
            d = $random(seed);
            sendPair(iType(`OP_SW, 16'(i * 4)), a, b, iType(`OP_SW, 16'(256 + i * 4)), c, d);
        end
        waitDrain();
        for (int i = 0; i < 16; i++)
        begin
            a = $random(seed) & 32'hffff_fc00;
            c = $random(seed) & 32'hffff_fc00;
            sendPair(iType(`OP_LW, 16'(256 + i * 4)), a, 32'h0,
                     iType(`OP_LW, 16'(i * 4)), c, 32'h0);
        end
        waitDrain();

        stallOn = 1'b1;
        for (int i = 0; i < 40; i++)
        begin
            a   = $random(seed);
            b   = $random(seed);
            imm = $random(seed);
            if (i % 3 == 0)
                sendPair(rType(`OP_SPECIAL, calcFuncts[i % 10], 5'd0), a, b,
                         iType(`OP_LW, 16'(256 + (i % 16) * 4)), 32'h0, 32'h0);
            else if (i % 3 == 1)
                sendPair(iType(immOps[i % 8], imm), a, b,
                         rType(`OP_SPECIAL, shiftFuncts[i % 6], imm[4:0]), b, a);
            else
                sendPair(iType(`OP_LW, 16'((i % 16) * 4)), 32'h0, 32'h0,
                         rType(`OP_SPECIAL2, `FN2_CLZ, 5'd0), a >> (i % 32), 32'h0);
        end
        waitDrain();
        stallOn = 1'b0;

        if (pending[0] != 0 || pending[1] != 0)
        begin
            $display("Expected results are left over at the end of the run");
            errorCount++;
        end
        $display("Run complete with %0d errors and %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tbClock.sv
`timescale 1ns/100ps
`default_nettype none

module tbClock (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

endmodule

`default_nettype wire

//--- design/mipsCluster.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
`default_nettype none

module mipsCluster (
    input  wire                    clk,
    input  wire                    rst,

    input  wire                    inst0Valid,
    output logic                   inst0Ready,
    input  wire [`DATA_WIDTH-1:0]  inst0Instr,
    input  wire [`DATA_WIDTH-1:0]  inst0Rs,
    input  wire [`DATA_WIDTH-1:0]  inst0Rt,
    output logic                   res0Valid,
    input  wire                    res0Ready,
    output logic [`DATA_WIDTH-1:0] res0Data,

    input  wire                    inst1Valid,
    output logic                   inst1Ready,
    input  wire [`DATA_WIDTH-1:0]  inst1Instr,
    input  wire [`DATA_WIDTH-1:0]  inst1Rs,
    input  wire [`DATA_WIDTH-1:0]  inst1Rt,
    output logic                   res1Valid,
    input  wire                    res1Ready,
    output logic [`DATA_WIDTH-1:0] res1Data
);

    memBus bus0 ();
    memBus bus1 ();

    execLane lane0 (
        .clk       (clk),
        .rst       (rst),
        .instValid (inst0Valid),
        .instReady (inst0Ready),
        .instInstr (inst0Instr),
        .instRs    (inst0Rs),
        .instRt    (inst0Rt),
        .resValid  (res0Valid),
        .resReady  (res0Ready),
        .resData   (res0Data),
        .mem       (bus0.lane)
    );

    execLane lane1 (
        .clk       (clk),
        .rst       (rst),
        .instValid (inst1Valid),
        .instReady (inst1Ready),
        .instInstr (inst1Instr),
        .instRs    (inst1Rs),
        .instRt    (inst1Rt),
        .resValid  (res1Valid),
        .resReady  (res1Ready),
        .resData   (res1Data),
        .mem       (bus1.lane)
    );

    // Both lanes share the single-port RAM
    sharedDataRam dataRam (
        .clk   (clk),
        .rst   (rst),
        .port0 (bus0.ram),
        .port1 (bus1.ram)
    );

endmodule

`default_nettype wire

//--- design/sharedDataRam.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
`default_nettype none

module sharedDataRam (
    input  wire clk,
    input  wire rst,
    memBus.ram  port0,
    memBus.ram  port1
);

    logic                       rrPtr;          // Lane that wins a tie
    logic                       gnt0;
    logic                       gnt1;
    logic                       selWe;
    logic [`RAM_ADDR_WIDTH-1:0] selAddr;
    logic [`DATA_WIDTH-1:0]     selWdata;
    logic [`DATA_WIDTH-1:0]     rdataQ;
    logic                       rvalid0Q;
    logic                       rvalid1Q;
    logic [`DATA_WIDTH-1:0]     memArray [0:`RAM_DEPTH-1];

    assign gnt0 = port0.req && (!port1.req || !rrPtr);
    assign gnt1 = port1.req && (!port0.req || rrPtr);

    assign port0.gnt = gnt0;
    assign port1.gnt = gnt1;

    assign selWe    = gnt1 ? port1.we    : port0.we;
    assign selAddr  = gnt1 ? port1.addr  : port0.addr;
    assign selWdata = gnt1 ? port1.wdata : port0.wdata;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rrPtr    <= 1'b0;
            rvalid0Q <= 1'b0;
            rvalid1Q <= 1'b0;
        end
        else
        begin
            rvalid0Q <= gnt0;
            rvalid1Q <= gnt1;
            if (gnt0 || gnt1)
                rrPtr <= gnt0;                  // The other lane goes first next time
        end
    end

    always_ff @(posedge clk)
    begin
        if (gnt0 || gnt1)
        begin
            if (selWe)
                memArray[selAddr] <= selWdata;
            rdataQ <= memArray[selAddr];
        end
    end

    // Only one lane sees rvalid so a shared read register is enough
    assign port0.rvalid = rvalid0Q;
    assign port1.rvalid = rvalid1Q;
    assign port0.rdata  = rdataQ;
    assign port1.rdata  = rdataQ;

    singleGrant: assert property (@(posedge clk) disable iff (rst)
        !(port0.gnt && port1.gnt));

endmodule

`default_nettype wire

//--- design/execLane.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
`default_nettype none

module execLane (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    instValid,
    output logic                   instReady,
    input  wire [`DATA_WIDTH-1:0]  instInstr,
    input  wire [`DATA_WIDTH-1:0]  instRs,
    input  wire [`DATA_WIDTH-1:0]  instRt,
    output logic                   resValid,
    input  wire                    resReady,
    output logic [`DATA_WIDTH-1:0] resData,
    memBus.lane                    mem
);
    import mipsPkg::*;

    laneStateE              state;
    instrClassE             cls;
    logic                   isMem;
    logic [`DATA_WIDTH-1:0] instrQ;
    logic [`DATA_WIDTH-1:0] rsQ;
    logic [`DATA_WIDTH-1:0] rtQ;
    logic [`DATA_WIDTH-1:0] aluOut;

    alu laneAlu (
        .instr  (instrQ),
        .dataRs (rsQ),
        .dataRt (rtQ),
        .out    (aluOut),
        .cls    (cls)
    );

    assign isMem     = (cls == clsMemRead) || (cls == clsMemWrite);
    assign instReady = (state == stIdle);
    assign resValid  = (state == stDone);

    // Request fields come from registered operands so they stay put until the grant
    assign mem.req   = (state == stMemReq);
    assign mem.we    = (cls == clsMemWrite);
    assign mem.addr  = aluOut[`RAM_ADDR_WIDTH+`ADDR_LSB-1:`ADDR_LSB];
    assign mem.wdata = rtQ;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= stIdle;
        end
        else
        begin
            case (state)
                stIdle:
                    if (instValid)
                        state <= stExec;
                stExec:
                    state <= isMem ? stMemReq : stDone;
                stMemReq:
                    if (mem.gnt)
                        state <= stMemWait;
                stMemWait:
                    if (mem.rvalid)
                        state <= stDone;
                stDone:
                    if (resReady)
                        state <= stIdle;
                default:
                    state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (instValid && instReady)
        begin
            instrQ <= instInstr;
            rsQ    <= instRs;
            rtQ    <= instRt;
        end
        if (state == stExec && !isMem)
            resData <= aluOut;
        if (state == stMemWait && mem.rvalid)
            resData <= (cls == clsMemRead) ? mem.rdata : aluOut; // Stores return the address
    end

    resultHeld: assert property (@(posedge clk) disable iff (rst)
        resValid && !resReady |=> resValid && $stable(resData));

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
`default_nettype none

module alu (
    input  wire [`DATA_WIDTH-1:0]  instr,
    input  wire [`DATA_WIDTH-1:0]  dataRs,
    input  wire [`DATA_WIDTH-1:0]  dataRt,
    output logic [`DATA_WIDTH-1:0] out,
    output mipsPkg::instrClassE    cls
);
    import mipsPkg::*;

    aluOpE                  aluOp;
    logic                   signExt;
    logic                   shiftByShamt;
    logic [4:0]             shamt;
    logic [15:0]            imm16;
    logic [`DATA_WIDTH-1:0] extImm;
    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] opB;

    instrDecoder decoder (
        .instr        (instr),
        .cls          (cls),
        .aluOp        (aluOp),
        .signExt      (signExt),
        .shiftByShamt (shiftByShamt)
    );

    // Counts zeros from the top bit down, 32 for an all-zero word
    function automatic logic [5:0] leadingZeros(input logic [`DATA_WIDTH-1:0] word);
        logic [5:0] count;
        logic       found;
        count = 6'd0;
        found = 1'b0;
        for (int i = `DATA_WIDTH - 1; i >= 0; i--)
        begin
            if (word[i])
                found = 1'b1;
            else if (!found)
                count = count + 6'd1;
        end
        return count;
    endfunction

    assign shamt  = instr[`SHAMT_HI:`SHAMT_LO];
    assign imm16  = instr[`IMM_HI:`IMM_LO];
    assign extImm = signExt ? {{16{imm16[15]}}, imm16} : {16'd0, imm16};

    assign opA = shiftByShamt ? {27'd0, shamt} : dataRs;

    always_comb
    begin
        case (cls)
            clsCalcI, clsMemRead, clsMemWrite: opB = extImm;
            clsCalcR:                          opB = dataRt;
            default:                           opB = '0;
        endcase
    end

    always_comb
    begin
        case (aluOp)
            aluAdd:  out = opA + opB;
            aluSub:  out = opA - opB;
            aluAnd:  out = opA & opB;
            aluOr:   out = opA | opB;
            aluXor:  out = opA ^ opB;
            aluNor:  out = ~(opA | opB);
            aluSlt:  out = {31'd0, $signed(opA) < $signed(opB)};
            aluSltu: out = {31'd0, opA < opB};
            aluSll:  out = opB << opA[4:0];             // Shifts move B by A
            aluSrl:  out = opB >> opA[4:0];
            aluSra:  out = $signed(opB) >>> opA[4:0];
            aluLui:  out = {opB[15:0], 16'd0};
            aluClo:  out = {26'd0, leadingZeros(~opA)};
            aluClz:  out = {26'd0, leadingZeros(opA)};
            default: out = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/instrDecoder.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
`default_nettype none

module instrDecoder (
    input  wire [`DATA_WIDTH-1:0] instr,
    output mipsPkg::instrClassE   cls,
    output mipsPkg::aluOpE        aluOp,
    output logic                  signExt,
    output logic                  shiftByShamt
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[`OPCODE_HI:`OPCODE_LO];
    assign funct  = instr[`FUNCT_HI:`FUNCT_LO];

    always_comb
    begin
        cls          = clsUnknown;
        aluOp        = aluZero;
        signExt      = 1'b1;
        shiftByShamt = 1'b0;
        case (opcode)
            `OP_SPECIAL:
            begin
                cls = clsCalcR;
                case (funct)
                    `FN_SLL:
                    begin
                        aluOp        = aluSll;
                        shiftByShamt = 1'b1;
                    end
                    `FN_SRL:
                    begin
                        aluOp        = aluSrl;
                        shiftByShamt = 1'b1;
                    end
                    `FN_SRA:
                    begin
                        aluOp        = aluSra;
                        shiftByShamt = 1'b1;
                    end
                    `FN_SLLV:            aluOp = aluSll;
                    `FN_SRLV:            aluOp = aluSrl;
                    `FN_SRAV:            aluOp = aluSra;
                    `FN_ADD, `FN_ADDU:   aluOp = aluAdd;  // No overflow trap on add
                    `FN_SUB, `FN_SUBU:   aluOp = aluSub;
                    `FN_AND:             aluOp = aluAnd;
                    `FN_OR:              aluOp = aluOr;
                    `FN_XOR:             aluOp = aluXor;
                    `FN_NOR:             aluOp = aluNor;
                    `FN_SLT:             aluOp = aluSlt;
                    `FN_SLTU:            aluOp = aluSltu;
                    default:             cls   = clsUnknown;
                endcase
            end
            `OP_SPECIAL2:
            begin
                cls = clsCalcR;
                case (funct)
                    `FN2_CLO: aluOp = aluClo;
                    `FN2_CLZ: aluOp = aluClz;
                    default:  cls   = clsUnknown;
                endcase
            end
            `OP_ADDI, `OP_ADDIU:
            begin
                cls   = clsCalcI;
                aluOp = aluAdd;
            end
            `OP_SLTI:
            begin
                cls   = clsCalcI;
                aluOp = aluSlt;
            end
            `OP_SLTIU:
            begin
                cls   = clsCalcI;
                aluOp = aluSltu;                           // Sign-extended, compared unsigned
            end
            `OP_ANDI:
            begin
                cls     = clsCalcI;
                aluOp   = aluAnd;
                signExt = 1'b0;
            end
            `OP_ORI:
            begin
                cls     = clsCalcI;
                aluOp   = aluOr;
                signExt = 1'b0;
            end
            `OP_XORI:
            begin
                cls     = clsCalcI;
                aluOp   = aluXor;
                signExt = 1'b0;
            end
            `OP_LUI:
            begin
                cls     = clsCalcI;
                aluOp   = aluLui;
                signExt = 1'b0;
            end
            `OP_LW:
            begin
                cls   = clsMemRead;
                aluOp = aluAdd;
            end
            `OP_SW:
            begin
                cls   = clsMemWrite;
                aluOp = aluAdd;
            end
            default:
            begin
                cls = clsUnknown;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/memBus.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
`default_nettype none

interface memBus ();

    logic                       req;
    logic                       we;
    logic [`RAM_ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0]     wdata;
    logic                       gnt;
    logic                       rvalid;     // One cycle after the grant, also for writes
    logic [`DATA_WIDTH-1:0]     rdata;

    modport lane (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport ram (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

//--- design/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef enum logic [3:0] {
        aluZero,
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui,
        aluClo,
        aluClz
    } aluOpE;

    typedef enum logic [2:0] {
        clsCalcR,
        clsCalcI,
        clsMemRead,
        clsMemWrite,
        clsUnknown
    } instrClassE;

    typedef enum logic [2:0] {
        stIdle,
        stExec,
        stMemReq,
        stMemWait,
        stDone
    } laneStateE;

endpackage

`default_nettype wire

//--- design/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`default_nettype none

`define DATA_WIDTH      32
`define RAM_ADDR_WIDTH  8
`define RAM_DEPTH       256
`define ADDR_LSB        2       // Byte offset bits below the word address

// Instruction fields
`define OPCODE_HI       31
`define OPCODE_LO       26
`define FUNCT_HI        5
`define FUNCT_LO        0
`define SHAMT_HI        10
`define SHAMT_LO        6
`define IMM_HI          15
`define IMM_LO          0

`define OP_SPECIAL      6'h00
`define OP_SPECIAL2     6'h1c
`define OP_ADDI         6'h08
`define OP_ADDIU        6'h09
`define OP_SLTI         6'h0a
`define OP_SLTIU        6'h0b
`define OP_ANDI         6'h0c
`define OP_ORI          6'h0d
`define OP_XORI         6'h0e
`define OP_LUI          6'h0f
`define OP_LW           6'h23
`define OP_SW           6'h2b

`define FN_SLL          6'h00
`define FN_SRL          6'h02
`define FN_SRA          6'h03
`define FN_SLLV         6'h04
`define FN_SRLV         6'h06
`define FN_SRAV         6'h07
`define FN_ADD          6'h20
`define FN_ADDU         6'h21
`define FN_SUB          6'h22
`define FN_SUBU         6'h23
`define FN_AND          6'h24
`define FN_OR           6'h25
`define FN_XOR          6'h26
`define FN_NOR          6'h27
`define FN_SLT          6'h2a
`define FN_SLTU         6'h2b
`define FN2_CLZ         6'h20   // Function codes under SPECIAL2
`define FN2_CLO         6'h21

`default_nettype wire

`endif
